// ==== src.f ====
+incdir+logic
logic/dqmStreamPkg.sv
logic/dqmFramePkg.sv
logic/bitFifo.sv
logic/payloadPingPong.sv
logic/headerShifter.sv
logic/frameSerializer.sv
logic/dqmFramer.sv
bench/dqmFramerTb.sv

// ==== Bender.yml ====
package:
  name: dqm_framer

export_include_dirs:
  - logic

sources:
  - logic/dqmStreamPkg.sv
  - logic/dqmFramePkg.sv
  - logic/bitFifo.sv
  - logic/payloadPingPong.sv
  - logic/headerShifter.sv
  - logic/frameSerializer.sv
  - logic/dqmFramer.sv
  - target: simulation
    files:
      - bench/dqmFramerTb.sv

// ==== bench/dqmFramerTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dqmFramer_cfg.svh"

module dqmFramerTb
    import dqmStreamPkg::*, dqmFramePkg::*;
();

    typedef logic bitQueue_t[$];

    logic          clk;
    logic          reset;
    framerCtrl_t   ctrl;
    logic [15:0]   dqm;
    payloadWrite_t payloadIn;
    logic          startOfFrame;
    serialBit_t    serialOut;
    bitQueue_t     expectedBits;
    string         testName;
    integer        seed;
    logic          ignoreOutput;

    dqmFramer dqmFramer_inst (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .dqm          (dqm),
        .payloadIn    (payloadIn),
        .startOfFrame (startOfFrame),
        .serialOut    (serialOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Header is sync word, 12 zeros, version, dqm, all msb first, then the payload
    function automatic bitQueue_t expectedFrame(input logic [15:0] dqmWord,
                                                input bitQueue_t payload);
        bitQueue_t   frame;
        logic [47:0] header;
        header = {16'(`DQM_SYNC_WORD), 12'h000, 4'(`DQM_VERSION), dqmWord};
        for (int i = 47; i >= 0; i--) begin
            frame.push_back(header[i]);
        end
        return {frame, payload};
    endfunction

    task automatic stopOnError();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkBit(input string name, input serialBit_t expected,
                            input serialBit_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %b actual %b", name, expected.value, actual.value);
            stopOnError();
        end
    endtask

    task automatic checkSpacing(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAILED %s spacing expected %0d actual %0d", name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkStartFlag(input string name, input logic expected,
                                  input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s startOfFrame expected %b actual %b", name, expected, actual);
            stopOnError();
        end
    endtask

    // Samples at posedge, so it sees the values settled during the previous cycle
    initial begin : outputMonitor
        int         gap;
        int         bitInFrame;
        string      name;
        serialBit_t expected;
        gap = 0;
        bitInFrame = 0;
        forever begin
            @(posedge clk);
            gap++;
            if (reset || ignoreOutput) begin
                bitInFrame = 0;
            end else if (serialOut.en) begin
                name = $sformatf("%s bit %0d", testName, bitInFrame);
                if (expectedBits.size() == 0) begin
                    $display("Output pulse with no frame pending in %s", name);
                    stopOnError();
                end else begin
                    if (bitInFrame != 0) begin
                        checkSpacing(name, int'(ctrl.clksPerBit) + 1, gap);
                    end
                    expected.en = 1'b1;
                    expected.value = expectedBits.pop_front();
                    checkBit(name, expected, serialOut);
                    gap = 0;
                    if (bitInFrame == `DQM_HEADER_BITS + int'(ctrl.payloadSize)) begin
                        bitInFrame = 0;
                    end else begin
                        bitInFrame++;
                    end
                end
            end
        end
    end

    // One strobe, then gap-1 quiet cycles
    // startOfFrame is high only ahead of the last bit of a frame
    task automatic writeBit(input logic value, input int gap, input logic lastBit);
        @(negedge clk);
        checkStartFlag(testName, lastBit, startOfFrame);
        payloadIn = '{en: 1'b1, value: value};
        @(negedge clk);
        payloadIn = '{en: 1'b0, value: 1'b0};
        repeat (gap - 1) @(negedge clk);
    endtask

    task automatic sendFrame(input logic [15:0] dqmWord, input int gap,
                             input logic expectOutput);
        bitQueue_t payload;
        integer    rnd;
        @(negedge clk);
        dqm = dqmWord;
        for (int i = 0; i <= int'(ctrl.payloadSize); i++) begin
            rnd = $random(seed);
            payload.push_back(rnd[0]);
        end
        if (expectOutput) begin
            expectedBits = {expectedBits, expectedFrame(dqmWord, payload)};
        end
        foreach (payload[i]) begin
            writeBit(payload[i], gap, i == int'(ctrl.payloadSize));
        end
    endtask

    task automatic waitForOutput();
        int cycles;
        cycles = 0;
        while (expectedBits.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                $display("Timeout: %0d frame bits never came out in %s",
                         expectedBits.size(), testName);
                stopOnError();
            end
        end
    endtask

    task automatic waitForFlushDrain();
        int cycles;
        cycles = 0;
        while (!(dqmFramer_inst.status.flushing && dqmFramer_inst.status.pingEmpty
                 && dqmFramer_inst.status.pongEmpty)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 5000) begin
                $display("Timeout: framer never flushed and drained both buffers");
                stopOnError();
            end
        end
    endtask

    initial begin
        seed = 43;
        reset = 1'b1;
        ctrl = '{payloadSize: 14'd31, clksPerBit: 16'd3};
        dqm = 16'h0000;
        payloadIn = '{en: 1'b0, value: 1'b0};
        ignoreOutput = 1'b0;
        testName = "reset idle";
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Any pulse here trips the monitor
        repeat (200) @(negedge clk);

        // First strobe after reset only leaves the flush state
        testName = "first frame";
        writeBit(1'b1, 24, 1'b0);
        sendFrame(16'hA5C3, 24, 1'b1);
        waitForOutput();

        testName = "ping pong";
        for (int i = 0; i < 4; i++) begin
            sendFrame(16'h1000 + 16'(i), 24, 1'b1);
        end
        waitForOutput();

        testName = "slow bit rate";
        @(negedge clk);
        ctrl.clksPerBit = 16'd6;
        sendFrame(16'h5A5A, 24, 1'b1);
        sendFrame(16'hC3C3, 24, 1'b1);
        waitForOutput();

        // Second frame lands while the first is still queued
        testName = "flush";
        ignoreOutput = 1'b1;
        sendFrame(16'h7777, 1, 1'b0);
        sendFrame(16'h8888, 1, 1'b0);
        waitForFlushDrain();
        ignoreOutput = 1'b0;
        writeBit(1'b0, 24, 1'b0);
        sendFrame(16'h2468, 24, 1'b1);
        waitForOutput();

        testName = "dqm change";
        sendFrame(16'hFFFF, 24, 1'b1);
        sendFrame(16'h0001, 24, 1'b1);
        waitForOutput();

        repeat (100) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/dqmFramer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dqmFramer import dqmStreamPkg::*, dqmFramePkg::*; (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire framerCtrl_t   ctrl,
    input  wire logic [15:0]   dqm,
    input  wire payloadWrite_t payloadIn,
    output logic               startOfFrame,
    output serialBit_t         serialOut
);

    bufferStatus_t status;
    logic          pingBit;
    logic          pongBit;
    logic          rdPing;
    logic          rdPong;
    logic          headerLoad;
    logic          headerShift;
    logic          headerBit;

    payloadPingPong buffers (
        .clk          (clk),
        .reset        (reset),
        .payloadIn    (payloadIn),
        .payloadSize  (ctrl.payloadSize),
        .rdPing       (rdPing),
        .rdPong       (rdPong),
        .startOfFrame (startOfFrame),
        .status       (status),
        .pingBit      (pingBit),
        .pongBit      (pongBit)
    );

    headerShifter header (
        .clk       (clk),
        .reset     (reset),
        .load      (headerLoad),
        .shift     (headerShift),
        .dqm       (dqm),
        .headerBit (headerBit)
    );

    frameSerializer serializer (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .payloadIn    (payloadIn),
        .startOfFrame (startOfFrame),
        .status       (status),
        .headerBit    (headerBit),
        .pingBit      (pingBit),
        .pongBit      (pongBit),
        .headerLoad   (headerLoad),
        .headerShift  (headerShift),
        .rdPing       (rdPing),
        .rdPong       (rdPong),
        .serialOut    (serialOut)
    );

endmodule

`default_nettype wire

// ==== logic/frameSerializer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dqmFramer_cfg.svh"

module frameSerializer import dqmStreamPkg::*, dqmFramePkg::*; (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire framerCtrl_t   ctrl,
    input  wire payloadWrite_t payloadIn,
    input  wire logic          startOfFrame,
    input  wire bufferStatus_t status,
    input  wire logic          headerBit,
    input  wire logic          pingBit,
    input  wire logic          pongBit,
    output logic               headerLoad,
    output logic               headerShift,
    output logic               rdPing,
    output logic               rdPong,
    output serialBit_t         serialOut
);

    localparam logic [13:0] lastHeaderCount = 14'(`DQM_HEADER_BITS - 1);

    serializerState_e state;
    logic [15:0]      divCount;
    logic [13:0]      shiftCount;
    logic             tick;
    logic             frameStart;
    logic             sending;

    // One tick every clksPerBit+1 cycles
    assign tick = (divCount == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            divCount <= '0;
        end else if (tick) begin
            divCount <= ctrl.clksPerBit;
        end else begin
            divCount <= divCount - 1'b1;
        end
    end

    assign frameStart = payloadIn.en && startOfFrame && !status.flushing;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            shiftCount <= '0;
        end else if (status.flushing) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (frameStart) begin
                        state <= WAIT;
                        shiftCount <= lastHeaderCount;
                    end
                end
                // First header bit leaves on the first tick
                WAIT: begin
                    if (tick) begin
                        state <= HEADER;
                        shiftCount <= shiftCount - 1'b1;
                    end
                end
                HEADER: begin
                    if (tick) begin
                        if (shiftCount == '0) begin
                            state <= PAYLOAD;
                            shiftCount <= ctrl.payloadSize;
                        end else begin
                            shiftCount <= shiftCount - 1'b1;
                        end
                    end
                end
                PAYLOAD: begin
                    if (tick) begin
                        if (shiftCount == '0) begin
                            state <= IDLE;
                        end else begin
                            shiftCount <= shiftCount - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign sending = (state != IDLE) && !status.flushing;
    assign headerLoad = (state == IDLE) && frameStart;
    assign headerShift = tick && sending && (state != PAYLOAD);

    always_comb begin
        rdPing = 1'b0;
        rdPong = 1'b0;
        if (status.flushing) begin
            // Drain both buffers
            rdPing = tick && !status.pingEmpty;
            rdPong = tick && !status.pongEmpty;
        end else if (state == PAYLOAD && tick) begin
            rdPing = status.readSelect;
            rdPong = !status.readSelect;
        end
    end

    assign serialOut.en = tick && sending;
    assign serialOut.value = (state == PAYLOAD) ?
        (status.readSelect ? pingBit : pongBit) : headerBit;

    assert property (@(posedge clk) disable iff (reset)
        (state == PAYLOAD && rdPing) |-> !status.pingEmpty)
        else $error("ping read empty during payload");
    assert property (@(posedge clk) disable iff (reset)
        (state == PAYLOAD && rdPong) |-> !status.pongEmpty)
        else $error("pong read empty during payload");

endmodule

`default_nettype wire

// ==== logic/headerShifter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dqmFramer_cfg.svh"

module headerShifter import dqmFramePkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        load,
    input  wire logic        shift,
    input  wire logic [15:0] dqm,
    output logic             headerBit
);

    frameHeader_t header;
    frameHeader_t nextHeader;

    // dqm is captured at frame start
    always_comb begin
        nextHeader.sync = `DQM_SYNC_WORD;
        nextHeader.reserved = '0;
        nextHeader.version = `DQM_VERSION;
        nextHeader.dqm = dqm;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            header <= nextHeader;
        end else if (shift) begin
            header <= {header[`DQM_HEADER_BITS-2:0], 1'b0};
        end
    end

    assign headerBit = header[`DQM_HEADER_BITS-1];

    assert property (@(posedge clk) disable iff (reset) !(load && shift))
        else $error("header load and shift in the same cycle");

endmodule

`default_nettype wire

// ==== logic/payloadPingPong.sv ====
`timescale 1ns/1ps
`default_nettype none

module payloadPingPong import dqmStreamPkg::*; (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire payloadWrite_t payloadIn,
    input  wire logic [13:0]   payloadSize,
    input  wire logic          rdPing,
    input  wire logic          rdPong,
    output logic               startOfFrame,
    output bufferStatus_t      status,
    output logic               pingBit,
    output logic               pongBit
);

    logic        flushing;
    logic [13:0] bitCount;
    logic        writePong;
    logic        readPing;
    logic        pingWr;
    logic        pongWr;
    logic        pingEmpty;
    logic        pongEmpty;
    logic        nextTargetBusy;

    assign startOfFrame = (bitCount == '0);

    assign pingWr = payloadIn.en && !flushing && !writePong;
    assign pongWr = payloadIn.en && !flushing && writePong;

    // Buffer that takes the frame after the current one
    assign nextTargetBusy = writePong ? !pingEmpty : !pongEmpty;

    assign status = '{
        pingEmpty:  pingEmpty,
        pongEmpty:  pongEmpty,
        readSelect: readPing,
        flushing:   flushing
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            flushing <= 1'b1;
            bitCount <= 14'd1;
            writePong <= 1'b0;
            readPing <= 1'b0;
        end else if (payloadIn.en) begin
            if (flushing) begin
                // The restart strobe itself is dropped
                if (pingEmpty && pongEmpty) begin
                    flushing <= 1'b0;
                    bitCount <= payloadSize;
                    writePong <= 1'b0;
                end
            end else if (bitCount == '0) begin
                // Last bit of the frame went to the current target
                bitCount <= payloadSize;
                writePong <= !writePong;
                readPing <= !writePong;
                flushing <= nextTargetBusy;
            end else begin
                bitCount <= bitCount - 1'b1;
            end
        end
    end

    bitFifo pingFifo (
        .clk   (clk),
        .reset (reset),
        .wrEn  (pingWr),
        .wrBit (payloadIn.value),
        .rdEn  (rdPing),
        .rdBit (pingBit),
        .empty (pingEmpty),
        .full  ()
    );

    bitFifo pongFifo (
        .clk   (clk),
        .reset (reset),
        .wrEn  (pongWr),
        .wrBit (payloadIn.value),
        .rdEn  (rdPong),
        .rdBit (pongBit),
        .empty (pongEmpty),
        .full  ()
    );

    // A buffer is never filled while the serializer drains it
    assert property (@(posedge clk) disable iff (reset)
        !((pingWr && rdPing) || (pongWr && rdPong)))
        else $error("buffer written while it is being read");

endmodule

`default_nettype wire

// ==== logic/bitFifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dqmFramer_cfg.svh"

module bitFifo (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic wrEn,
    input  wire logic wrBit,
    input  wire logic rdEn,
    output logic      rdBit,
    output logic      empty,
    output logic      full
);

    localparam int fifoDepth = `DQM_FIFO_DEPTH;
    localparam int addrBits = $clog2(fifoDepth);
    localparam logic [addrBits-1:0] lastAddr = addrBits'(fifoDepth - 1);
    localparam logic [addrBits:0] fullCount = (addrBits + 1)'(fifoDepth);

    logic                mem [fifoDepth];
    logic [addrBits-1:0] wrPtr;
    logic [addrBits-1:0] rdPtr;
    logic [addrBits:0]   count;
    logic [addrBits:0]   nextCount;
    logic                doWrite;
    logic                doRead;

    assign doWrite = wrEn && !full;
    assign doRead = rdEn && !empty;

    // First-word fall-through
    assign rdBit = mem[rdPtr];

    always_comb begin
        nextCount = count;
        if (doWrite && !doRead) begin
            nextCount = count + 1'b1;
        end else if (doRead && !doWrite) begin
            nextCount = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrBit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            empty <= 1'b1;
            full <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == lastAddr) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == lastAddr) ? '0 : rdPtr + 1'b1;
            end
            count <= nextCount;
            empty <= (nextCount == '0);
            full <= (nextCount == fullCount);
        end
    end

    assert property (@(posedge clk) disable iff (reset) wrEn |-> !full)
        else $error("bitFifo written while full");
    assert property (@(posedge clk) disable iff (reset) rdEn |-> !empty)
        else $error("bitFifo read while empty");

endmodule

`default_nettype wire

// ==== logic/dqmFramePkg.sv ====
`default_nettype none

package dqmFramePkg;

    typedef struct packed {
        logic [13:0] payloadSize;
        logic [15:0] clksPerBit;
    } framerCtrl_t;

    // Sent msb first, sync word leads
    typedef struct packed {
        logic [15:0] sync;
        logic [11:0] reserved;
        logic [3:0]  version;
        logic [15:0] dqm;
    } frameHeader_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        HEADER,
        PAYLOAD
    } serializerState_e;

endpackage

`default_nettype wire

// ==== logic/dqmStreamPkg.sv ====
`default_nettype none

package dqmStreamPkg;

    // Incoming payload strobe and its data bit
    typedef struct packed {
        logic en;
        logic value;
    } payloadWrite_t;

    // Framed output, en is a one-cycle pulse per bit
    typedef struct packed {
        logic en;
        logic value;
    } serialBit_t;

    // Buffer state seen by the serializer
    // readSelect set means the frame to send sits in ping
    typedef struct packed {
        logic pingEmpty;
        logic pongEmpty;
        logic readSelect;
        logic flushing;
    } bufferStatus_t;

endpackage

`default_nettype wire

// ==== logic/dqmFramer_cfg.svh ====
`ifndef DQM_FRAMER_CFG_SVH
`define DQM_FRAMER_CFG_SVH

// Frame sync pattern
`define DQM_SYNC_WORD   16'hEB90

// Header format version
`define DQM_VERSION     4'd1

// Bits per buffer, must hold payloadSize+1
`define DQM_FIFO_DEPTH  16384

`define DQM_HEADER_BITS 48

`endif
